// File: hdl/rvc_settings.svh
`ifndef RVC_SETTINGS_SVH
`define RVC_SETTINGS_SVH

// Byte address of the first fetch, word aligned
`define RVC_RESET_PC 32'h0000_0000

// Parcel slots in the fetch queue, even and at least 4
`define RVC_QUEUE_DEPTH 8

// Wishbone word address width
`define RVC_WB_ADDR_W 30

`endif

// File: hdl/rvc_pkg.sv
`include "rvc_settings.svh"

package rvc_pkg;

  // R-type field layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t;

  // I-type field layout
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  // One instruction word, two decodings
  typedef union packed {
    rv_r_t r_view;
    rv_i_t i_view;
  } rv_instr_u;

  typedef struct packed {
    logic [31:0] pc;
    rv_instr_u   instr;
    logic        compressed;
    logic        illegal;
  } fetch_out_t;

  // Classic Wishbone read request, word addressed
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic [`RVC_WB_ADDR_W-1:0] adr;
  } wb_req_t;

endpackage

// File: hdl/fetch_master.sv
`include "rvc_settings.svh"

module fetch_master (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             room,
  input  logic [31:0]      wb_dat,
  input  logic             wb_ack,
  output rvc_pkg::wb_req_t wb,
  output logic             wr_en,
  output logic [31:0]      wr_word
);

  localparam logic [31:0] RESET_PC = `RVC_RESET_PC;

  logic                      busy;
  logic [`RVC_WB_ADDR_W-1:0] adr;

  // One outstanding cycle at most
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      adr  <= RESET_PC[`RVC_WB_ADDR_W+1:2];
    end else if (!busy) begin
      busy <= room;
    end else if (wb_ack) begin
      // Back to back when the queue can take another word
      busy <= room;
      adr  <= adr + 1'b1;
    end
  end

  assign wb = '{cyc: busy, stb: busy, adr: adr};

  // Acked word goes straight into the queue
  assign wr_en   = busy & wb_ack;
  assign wr_word = wb_dat;

endmodule

// File: hdl/parcel_queue.sv
`include "rvc_settings.svh"

module parcel_queue #(
  parameter int DEPTH = `RVC_QUEUE_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_en,
  input  logic [31:0]                wr_word,
  input  logic                       pop1,
  input  logic                       pop2,
  input  logic                       fetch_busy,
  output logic                       room,
  output logic [15:0]                head0,
  output logic [15:0]                head1,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH+1);

  logic [15:0]   slots [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW-1:0] rd_ptr_inc;
  logic [CW-1:0] count_in;
  logic [CW-1:0] count_out;
  logic [CW:0]   used;

  // Modulo DEPTH increment, DEPTH need not be a power of two
  function automatic logic [PW-1:0] ptr_add(input logic [PW-1:0] ptr, input logic [1:0] step);
    logic [PW:0] sum;
    sum = {1'b0, ptr} + {{(PW-1){1'b0}}, step};
    if (sum >= (PW+1)'(DEPTH)) begin
      sum = sum - (PW+1)'(DEPTH);
    end
    return sum[PW-1:0];
  endfunction

  assign count_in  = wr_en ? CW'(2) : '0;
  assign count_out = pop2 ? CW'(2) : (pop1 ? CW'(1) : '0);

  // In-flight word already owns two slots
  assign used = {1'b0, count} + (fetch_busy ? (CW+1)'(2) : '0);
  assign room = used <= (CW+1)'(DEPTH - 2);

  // wr_ptr stays even, so the upper parcel never wraps
  always_ff @(posedge clk) begin
    if (wr_en) begin
      slots[wr_ptr]        <= wr_word[15:0];
      slots[wr_ptr + 1'b1] <= wr_word[31:16];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_add(wr_ptr, 2'd2);
      end
      if (pop1 || pop2) begin
        rd_ptr <= ptr_add(rd_ptr, pop2 ? 2'd2 : 2'd1);
      end
      count <= count + count_in - count_out;
    end
  end

  assign rd_ptr_inc = ptr_add(rd_ptr, 2'd1);
  assign head0      = slots[rd_ptr];
  assign head1      = slots[rd_ptr_inc];

endmodule

// File: hdl/rvc_expander.sv
module rvc_expander (
  input  logic [15:0]        parcel,
  output rvc_pkg::rv_instr_u instr,
  output logic               illegal
);

  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  rd_c;
  logic [4:0]  rs2_c;
  logic [11:0] imm6_sext;
  logic [11:0] lw_off;

  assign rd_full  = parcel[11:7];
  assign rs2_full = parcel[6:2];

  // Compressed register fields address x8..x15
  assign rd_c  = {2'b01, parcel[9:7]};
  assign rs2_c = {2'b01, parcel[4:2]};

  assign imm6_sext = {{7{parcel[12]}}, parcel[6:2]};
  assign lw_off    = {5'b00000, parcel[5], parcel[12:10], parcel[6], 2'b00};

  always_comb begin
    instr   = {16'h0000, parcel};
    illegal = 1'b1;
    case ({parcel[15:13], parcel[1:0]})
      // C.LW
      5'b010_00: begin
        instr.i_view.imm    = lw_off;
        instr.i_view.rs1    = rd_c;
        instr.i_view.funct3 = 3'b010;
        instr.i_view.rd     = rs2_c;
        instr.i_view.opcode = OP_LOAD;
        illegal             = 1'b0;
      end
      // C.SW with the offset split across funct7 and rd
      5'b110_00: begin
        instr.r_view.funct7 = lw_off[11:5];
        instr.r_view.rs2    = rs2_c;
        instr.r_view.rs1    = rd_c;
        instr.r_view.funct3 = 3'b010;
        instr.r_view.rd     = lw_off[4:0];
        instr.r_view.opcode = OP_STORE;
        illegal             = 1'b0;
      end
      // C.ADDI and C.LI
      5'b000_01, 5'b010_01: begin
        instr.i_view.imm    = imm6_sext;
        instr.i_view.rs1    = parcel[14] ? 5'd0 : rd_full;
        instr.i_view.funct3 = 3'b000;
        instr.i_view.rd     = rd_full;
        instr.i_view.opcode = OP_IMM;
        illegal             = 1'b0;
      end
      // C.LUI unless rd is x2 (C.ADDI16SP)
      5'b011_01: begin
        instr.i_view.imm    = {12{parcel[12]}};
        instr.i_view.rs1    = {{3{parcel[12]}}, parcel[6:5]};
        instr.i_view.funct3 = parcel[4:2];
        instr.i_view.rd     = rd_full;
        instr.i_view.opcode = OP_LUI;
        illegal             = (rd_full == 5'd2) || ({parcel[12], parcel[6:2]} == 6'd0);
      end
      5'b100_01: begin
        case (parcel[11:10])
          // C.SRLI and C.SRAI with shamt[5] reserved on RV32
          2'b00, 2'b01: begin
            instr.i_view.imm    = {1'b0, parcel[10], 5'b00000, parcel[6:2]};
            instr.i_view.rs1    = rd_c;
            instr.i_view.funct3 = 3'b101;
            instr.i_view.rd     = rd_c;
            instr.i_view.opcode = OP_IMM;
            illegal             = parcel[12];
          end
          // C.ANDI
          2'b10: begin
            instr.i_view.imm    = imm6_sext;
            instr.i_view.rs1    = rd_c;
            instr.i_view.funct3 = 3'b111;
            instr.i_view.rd     = rd_c;
            instr.i_view.opcode = OP_IMM;
            illegal             = 1'b0;
          end
          // C.SUB, C.XOR, C.OR, C.AND
          default: begin
            instr.r_view.funct7 = (parcel[6:5] == 2'b00) ? 7'b0100000 : 7'b0000000;
            instr.r_view.rs2    = rs2_c;
            instr.r_view.rs1    = rd_c;
            case (parcel[6:5])
              2'b00:   instr.r_view.funct3 = 3'b000;
              2'b01:   instr.r_view.funct3 = 3'b100;
              2'b10:   instr.r_view.funct3 = 3'b110;
              default: instr.r_view.funct3 = 3'b111;
            endcase
            instr.r_view.rd     = rd_c;
            instr.r_view.opcode = OP_REG;
            illegal             = parcel[12];
          end
        endcase
      end
      // C.BEQZ and C.BNEZ
      5'b110_01, 5'b111_01: begin
        instr.r_view.funct7 = {{4{parcel[12]}}, parcel[6:5], parcel[2]};
        instr.r_view.rs2    = 5'd0;
        instr.r_view.rs1    = rd_c;
        instr.r_view.funct3 = {2'b00, parcel[13]};
        instr.r_view.rd     = {parcel[11:10], parcel[4:3], parcel[12]};
        instr.r_view.opcode = OP_BRANCH;
        illegal             = 1'b0;
      end
      // C.SLLI
      5'b000_10: begin
        instr.i_view.imm    = {7'b0000000, parcel[6:2]};
        instr.i_view.rs1    = rd_full;
        instr.i_view.funct3 = 3'b001;
        instr.i_view.rd     = rd_full;
        instr.i_view.opcode = OP_IMM;
        illegal             = parcel[12];
      end
      // C.MV and C.ADD unless rs2 is x0 (jumps and ebreak)
      5'b100_10: begin
        instr.r_view.funct7 = 7'b0000000;
        instr.r_view.rs2    = rs2_full;
        instr.r_view.rs1    = parcel[12] ? rd_full : 5'd0;
        instr.r_view.funct3 = 3'b000;
        instr.r_view.rd     = rd_full;
        instr.r_view.opcode = OP_REG;
        illegal             = rs2_full == 5'd0;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
    if (illegal) begin
      instr = {16'h0000, parcel};
    end
  end

endmodule

// File: hdl/instr_aligner.sv
`include "rvc_settings.svh"

module instr_aligner #(
  parameter int DEPTH = `RVC_QUEUE_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [15:0]                head0,
  input  logic [15:0]                head1,
  input  logic [$clog2(DEPTH+1)-1:0] count,
  input  logic                       out_ready,
  output logic                       pop1,
  output logic                       pop2,
  output rvc_pkg::fetch_out_t        out,
  output logic                       out_valid
);

  rvc_pkg::rv_instr_u exp_instr;
  logic               exp_illegal;
  logic               need1;
  logic               avail;
  logic               load;
  logic [31:0]        pc;

  rvc_expander expander_i (
    .parcel  (head0),
    .instr   (exp_instr),
    .illegal (exp_illegal)
  );

  // Low bits 11 mean a full 32-bit instruction
  assign need1 = head0[1:0] != 2'b11;
  assign avail = (count >= 2) || ((count == 1) && need1);

  // Output slot free or draining this cycle
  assign load = avail && (!out_valid || out_ready);
  assign pop1 = load && need1;
  assign pop2 = load && !need1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      pc        <= `RVC_RESET_PC;
    end else if (load) begin
      out_valid <= 1'b1;
      pc        <= pc + (need1 ? 32'd2 : 32'd4);
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out.pc         <= pc;
      out.instr      <= need1 ? exp_instr : rvc_pkg::rv_instr_u'({head1, head0});
      out.compressed <= need1;
      out.illegal    <= need1 && exp_illegal;
    end
  end

endmodule

// File: hdl/rvc_fetch_top.sv
`include "rvc_settings.svh"

module rvc_fetch_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [31:0]         wb_dat,
  input  logic                wb_ack,
  input  logic                out_ready,
  output rvc_pkg::wb_req_t    wb,
  output rvc_pkg::fetch_out_t out,
  output logic                out_valid
);

  logic                                    room;
  logic                                    wr_en;
  logic [31:0]                             wr_word;
  logic                                    pop1;
  logic                                    pop2;
  logic [15:0]                             head0;
  logic [15:0]                             head1;
  logic [$clog2(`RVC_QUEUE_DEPTH+1)-1:0]   count;

  fetch_master master_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .room    (room),
    .wb_dat  (wb_dat),
    .wb_ack  (wb_ack),
    .wb      (wb),
    .wr_en   (wr_en),
    .wr_word (wr_word)
  );

  // Open bus cycle reserves queue room
  parcel_queue #(
    .DEPTH (`RVC_QUEUE_DEPTH)
  ) queue_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_word    (wr_word),
    .pop1       (pop1),
    .pop2       (pop2),
    .fetch_busy (wb.cyc),
    .room       (room),
    .head0      (head0),
    .head1      (head1),
    .count      (count)
  );

  instr_aligner #(
    .DEPTH (`RVC_QUEUE_DEPTH)
  ) aligner_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .head0     (head0),
    .head1     (head1),
    .count     (count),
    .out_ready (out_ready),
    .pop1      (pop1),
    .pop2      (pop2),
    .out       (out),
    .out_valid (out_valid)
  );

endmodule

// File: test/rvc_fetch_assertions.sv
module rvc_fetch_assertions (
  input logic                clk,
  input logic                rst_n,
  input rvc_pkg::wb_req_t    wb,
  input logic                wb_ack,
  input rvc_pkg::fetch_out_t out,
  input logic                out_valid,
  input logic                out_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // Request held with the same address until the slave acks
  stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb.stb && !wb_ack |=> wb.stb && $stable(wb.adr))
    else begin
      fail_count++;
      $error("stb dropped or adr changed before ack");
    end

  // Output held while stalled
  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out))
    else begin
      fail_count++;
      $error("out changed while out_valid high and out_ready low");
    end

  // Fetch is strictly sequential
  adr_step: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(wb.adr) |-> wb.adr == $past(wb.adr) + 1'b1)
    else begin
      fail_count++;
      $error("adr did not step by one word");
    end

endmodule

bind rvc_fetch_top rvc_fetch_assertions assert_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .wb        (wb),
  .wb_ack    (wb_ack),
  .out       (out),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

// File: test/rvc_fetch_tb.sv
`include "rvc_settings.svh"

module rvc_fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] RESET_PC = `RVC_RESET_PC;
  localparam int N_LEGAL = 17;
  localparam int N_KINDS = 21;

  // Fixed bits of the 17 supported forms, then C.JAL, C.LWSP, C.ADDI4SPN and C.J
  localparam logic [15:0] FIXED_MASK [N_KINDS] = '{
    16'hE003, 16'hE003, 16'hE003, 16'hE003, 16'hE003, 16'hFC03, 16'hFC03,
    16'hEC03, 16'hFC63, 16'hFC63, 16'hFC63, 16'hFC63, 16'hF003, 16'hF003,
    16'hF003, 16'hE003, 16'hE003, 16'hE003, 16'hE003, 16'hE003, 16'hE003};
  localparam logic [15:0] FIXED_VAL [N_KINDS] = '{
    16'h4000, 16'hC000, 16'h0001, 16'h4001, 16'h6001, 16'h8001, 16'h8401,
    16'h8801, 16'h8C01, 16'h8C21, 16'h8C41, 16'h8C61, 16'h8002, 16'h9002,
    16'h0002, 16'hC001, 16'hE001, 16'h2001, 16'h4002, 16'h0000, 16'hA001};

  logic                clk = 1'b0;
  logic                rst_n = 1'b0;
  logic [31:0]         wb_dat = '0;
  logic                wb_ack = 1'b0;
  logic                out_ready = 1'b0;
  rvc_pkg::wb_req_t    wb;
  rvc_pkg::fetch_out_t out;
  logic                out_valid;

  logic [15:0] rom [$];
  logic        rom_built = 1'b0;
  int          wait_left = 0;
  int          ready_left = 0;

  rvc_fetch_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_dat    (wb_dat),
    .wb_ack    (wb_ack),
    .out_ready (out_ready),
    .wb        (wb),
    .out       (out),
    .out_valid (out_valid)
  );

  always #10 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      stop_run($sformatf("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, want));
    end
  endtask

  function automatic logic [15:0] make_parcel(input int kind);
    logic [15:0] p;
    p = (16'($urandom) & ~FIXED_MASK[kind]) | FIXED_VAL[kind];
    // C.LUI with rd=x2 or a zero immediate is another instruction
    if (kind == 4 && p[11:7] == 5'd2) begin
      p[11:7] = 5'd3;
    end
    if ((kind == 4 && {p[12], p[6:2]} == 6'd0) ||
        ((kind == 12 || kind == 13) && p[6:2] == 5'd0)) begin
      p[2] = 1'b1;
    end
    return p;
  endfunction

  task automatic push_word32();
    logic [31:0] w;
    w = $urandom | 32'h3;
    rom.push_back(w[15:0]);
    rom.push_back(w[31:16]);
  endtask

  function automatic rvc_pkg::fetch_out_t expand_ref(input logic [31:0] pc,
                                                    input logic [15:0] lo,
                                                    input logic [15:0] hi);
    rvc_pkg::fetch_out_t r;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs2p;
    logic [2:0]  f3;
    logic [11:0] simm;
    logic [11:0] uoff;
    logic [12:0] boff;
    logic [31:0] w;
    logic        bad;
    r.pc         = pc;
    r.compressed = lo[1:0] != 2'b11;
    r.illegal    = 1'b0;
    r.instr      = {hi, lo};
    if (!r.compressed) begin
      return r;
    end
    rd   = lo[11:7];
    rs2  = lo[6:2];
    rdp  = {2'b01, lo[9:7]};
    rs2p = {2'b01, lo[4:2]};
    simm = {{7{lo[12]}}, lo[6:2]};
    uoff = {5'd0, lo[5], lo[12:10], lo[6], 2'b00};
    boff = {{5{lo[12]}}, lo[6:5], lo[2], lo[11:10], lo[4:3], 1'b0};
    case (lo[6:5])
      2'b00:   f3 = 3'b000;
      2'b01:   f3 = 3'b100;
      2'b10:   f3 = 3'b110;
      default: f3 = 3'b111;
    endcase
    w   = '0;
    bad = 1'b0;
    case ({lo[15:13], lo[1:0]})
      5'b010_00: w = {uoff, rdp, 3'b010, rs2p, 7'b0000011};
      5'b110_00: w = {uoff[11:5], rs2p, rdp, 3'b010, uoff[4:0], 7'b0100011};
      5'b000_01: w = {simm, rd, 3'b000, rd, 7'b0010011};
      5'b010_01: w = {simm, 5'd0, 3'b000, rd, 7'b0010011};
      5'b011_01: begin
        w   = {{15{lo[12]}}, lo[6:2], rd, 7'b0110111};
        bad = rd == 5'd2 || {lo[12], lo[6:2]} == 6'd0;
      end
      5'b100_01: begin
        case (lo[11:10])
          2'b00:   w = {7'b0000000, lo[6:2], rdp, 3'b101, rdp, 7'b0010011};
          2'b01:   w = {7'b0100000, lo[6:2], rdp, 3'b101, rdp, 7'b0010011};
          2'b10:   w = {simm, rdp, 3'b111, rdp, 7'b0010011};
          default: w = {(lo[6:5] == 2'b00) ? 7'b0100000 : 7'b0000000, rs2p, rdp, f3, rdp,
                        7'b0110011};
        endcase
        bad = lo[12] && lo[11:10] != 2'b10;
      end
      5'b110_01, 5'b111_01: begin
        w = {boff[12], boff[10:5], 5'd0, rdp, 2'b00, lo[13], boff[4:1], boff[11], 7'b1100011};
      end
      5'b000_10: begin
        w   = {7'b0000000, lo[6:2], rd, 3'b001, rd, 7'b0010011};
        bad = lo[12];
      end
      5'b100_10: begin
        w   = {7'b0000000, rs2, (lo[12] ? rd : 5'd0), 3'b000, rd, 7'b0110011};
        bad = rs2 == 5'd0;
      end
      default: bad = 1'b1;
    endcase
    r.illegal = bad;
    r.instr   = bad ? {16'h0000, lo} : w;
    return r;
  endfunction

  function automatic logic [31:0] rom_word(input logic [`RVC_WB_ADDR_W-1:0] adr);
    int idx;
    idx = 2 * (int'(adr) - int'(RESET_PC[31:2]));
    if (idx >= 0 && idx + 1 < rom.size()) begin
      return {rom[idx + 1], rom[idx]};
    end
    // Words past the program are 32-bit instructions built from the address
    return 32'({adr, 2'b11});
  endfunction

  initial begin
    void'($urandom(32'he0e94f5c));
    repeat (16) begin
      push_word32();
    end
    for (int k = 0; k < N_LEGAL; k++) begin
      repeat (4) begin
        rom.push_back(make_parcel(k));
      end
    end
    // Odd offsets make 32-bit words straddle
    repeat (80) begin
      if ($urandom_range(1, 0) == 0) begin
        push_word32();
      end else begin
        rom.push_back(make_parcel($urandom_range(N_LEGAL - 1, 0)));
      end
    end
    repeat (12) begin
      rom.push_back(make_parcel($urandom_range(N_KINDS - 1, N_LEGAL)));
      push_word32();
    end
    if (rom.size() % 2 != 0) begin
      rom.push_back(make_parcel(2));
    end
    rom_built = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
  end

  // Wishbone ROM slave
  always @(negedge clk) begin
    if (!rst_n || wb_ack) begin
      wb_ack    = 1'b0;
      wait_left = $urandom_range(3, 0);
    end else if (wb.cyc && wb.stb) begin
      if (wait_left == 0) begin
        wb_ack = 1'b1;
        wb_dat = rom_word(wb.adr);
      end else begin
        wait_left--;
      end
    end
  end

  // Long random stalls on the output
  always @(negedge clk) begin
    if (!rst_n) begin
      out_ready = 1'b0;
    end else if (ready_left == 0) begin
      out_ready  = $urandom_range(9, 0) >= 4;
      ready_left = $urandom_range(24, 1);
    end else begin
      ready_left--;
    end
  end

  always @(negedge clk) begin
    if (dut_i.assert_i.fail_count != 0) begin
      stop_run("A bound assertion on the DUT failed");
    end
  end

  initial begin
    rvc_pkg::fetch_out_t want;
    int                  p;
    logic [31:0]         pc;
    p  = 0;
    pc = RESET_PC;
    wait (rom_built);
    while (p < rom.size()) begin
      @(posedge clk);
      if (rst_n && out_valid && out_ready) begin
        want = expand_ref(pc, rom[p], (p + 1 < rom.size()) ? rom[p + 1] : 16'h0000);
        compare("out.pc", out.pc, want.pc);
        compare("out.instr", out.instr, want.instr);
        compare("out.compressed", 32'(out.compressed), 32'(want.compressed));
        compare("out.illegal", 32'(out.illegal), 32'(want.illegal));
        p  = p + (want.compressed ? 1 : 2);
        pc = pc + (want.compressed ? 32'd2 : 32'd4);
      end
    end
    if (dut_i.assert_i.fail_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_run("A bound assertion on the DUT failed");
    end
  end

  // Watchdog
  initial begin
    wait (rom_built);
    repeat ((rom.size() + `RVC_QUEUE_DEPTH) * 40) @(posedge clk);
    stop_run("Timeout: not every instruction came out in the allowed number of cycles");
  end

endmodule

// File: rvc_fetch_top.f
+incdir+hdl
hdl/rvc_pkg.sv
hdl/fetch_master.sv
hdl/parcel_queue.sv
hdl/rvc_expander.sv
hdl/instr_aligner.sv
hdl/rvc_fetch_top.sv
test/rvc_fetch_assertions.sv
test/rvc_fetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := rvc_fetch_tb
FILELIST  := rvc_fetch_top.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation ended without passing"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
